/* design/fe_pkg.sv */
package fe_pkg;

    // boot address of the core
    localparam logic [31:0] RESET_PC = 32'h1c000000;

    // slots per fetch and per issue
    localparam int FETCH_WIDTH = 2;

    localparam int RAW_FIFO_DEPTH = 8;
    localparam int DEC_FIFO_DEPTH = 4;

    // register usage classes
    localparam logic [2:0] REG_TYPE_I   = 3'd0;
    localparam logic [2:0] REG_TYPE_RW  = 3'd1;
    localparam logic [2:0] REG_TYPE_RRW = 3'd2;
    localparam logic [2:0] REG_TYPE_RR  = 3'd3;
    localparam logic [2:0] REG_TYPE_BL  = 3'd4;

    // three-register format
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_3r_t;

    // two registers plus 12-bit immediate
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
    } inst_word_u;

    // {fetch_err, pc, word}
    localparam int RAW_ENTRY_W = 1 + 32 + 32;

    // raw entry followed by r_reg0, r_reg1, w_reg and imm
    localparam int DEC_ENTRY_W = RAW_ENTRY_W + 3 * 5 + 32;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        flush_i,
    input  logic [31:0] redirect_pc_i,

    input  logic        fifo_ready_i,

    output logic        fetch_req_o,
    output logic [31:0] fetch_addr_o,
    input  logic        fetch_resp_valid_i,
    input  logic [63:0] fetch_data_i,
    input  logic        fetch_err_i,

    output logic [1:0]  write_num_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::RAW_ENTRY_W-1:0] write_data_o
);
    import fe_pkg::*;

    logic [31:0] pc;
    logic [31:0] req_pc;
    logic        started;
    logic        outstanding;
    logic        drop;
    logic        resp_keep;
    logic [31:0] pc_lo;
    logic [31:0] pc_hi;

    // one request in flight at most, none in a flush cycle
    assign fetch_req_o  = started & ~outstanding & fifo_ready_i & ~flush_i;
    assign fetch_addr_o = {pc[31:3], 3'b000};

    assign resp_keep = fetch_resp_valid_i & ~drop & ~flush_i;

    assign pc_lo = {req_pc[31:3], 3'b000};
    assign pc_hi = {req_pc[31:3], 3'b100};

    // entering mid-pair keeps only the upper word, packed into slot 0
    always_comb begin
        write_num_o = 2'd0;
        if (resp_keep) begin
            write_num_o = req_pc[2] ? 2'd1 : 2'd2;
        end
        if (req_pc[2]) begin
            write_data_o[0] = {fetch_err_i, pc_hi, fetch_data_i[63:32]};
        end else begin
            write_data_o[0] = {fetch_err_i, pc_lo, fetch_data_i[31:0]};
        end
        write_data_o[1] = {fetch_err_i, pc_hi, fetch_data_i[63:32]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (flush_i) begin
                pc <= redirect_pc_i;
            end else if (fetch_req_o) begin
                pc <= fetch_addr_o + 32'd8;
            end
        end
    end

    // request pc is payload, only meaningful while outstanding
    always_ff @(posedge clk) begin
        if (fetch_req_o) begin
            req_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
            drop        <= 1'b0;
        end else begin
            if (fetch_resp_valid_i) begin
                outstanding <= 1'b0;
                drop        <= 1'b0;
            end else if (fetch_req_o) begin
                outstanding <= 1'b1;
            end else if (flush_i && outstanding) begin
                // stale response still has to come back before refetch
                drop <= 1'b1;
            end
        end
    end

endmodule

/* design/multi_channel_fifo.sv */
`timescale 1ns/1ps

module multi_channel_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 8
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       flush_i,

    output logic       write_ready_o,
    input  logic [1:0] write_num_i,
    input  logic [fe_pkg::FETCH_WIDTH-1:0][DATA_WIDTH-1:0] write_data_i,

    output logic [1:0] read_valid_o,
    input  logic       read_ready_i,
    input  logic [1:0] read_num_i,
    output logic [fe_pkg::FETCH_WIDTH-1:0][DATA_WIDTH-1:0] read_data_o
);
    import fe_pkg::*;

    // DEPTH is a power of two, pointers wrap on their own
    logic [DATA_WIDTH-1:0]      mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic [1:0]                 wr_cnt;
    logic [1:0]                 rd_cnt;
    logic [1:0]                 avail;

    assign write_ready_o = (int'(count) + FETCH_WIDTH) <= DEPTH;

    assign read_valid_o[0] = count != '0;
    assign read_valid_o[1] = int'(count) >= 2;

    assign avail = read_valid_o[1] ? 2'd2 : {1'b0, read_valid_o[0]};

    always_comb begin
        wr_cnt = write_ready_o ? write_num_i : 2'd0;
        rd_cnt = 2'd0;
        if (read_ready_i) begin
            // never pop more than is stored
            rd_cnt = (read_num_i > avail) ? avail : read_num_i;
        end
    end

    assign read_data_o[0] = mem[rd_ptr];
    assign read_data_o[1] = mem[rd_ptr + 1'b1];

    always_ff @(posedge clk) begin
        if (!flush_i) begin
            if (wr_cnt != 2'd0) begin
                mem[wr_ptr] <= write_data_i[0];
            end
            if (wr_cnt == 2'd2) begin
                mem[wr_ptr + 1'b1] <= write_data_i[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ($clog2(DEPTH))'(wr_cnt);
            rd_ptr <= rd_ptr + ($clog2(DEPTH))'(rd_cnt);
            count  <= count + ($clog2(DEPTH) + 1)'(wr_cnt)
                            - ($clog2(DEPTH) + 1)'(rd_cnt);
        end
    end

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0] inst_i,
    input  logic        fetch_err_i,

    output logic [4:0]  r_reg0_o,
    output logic [4:0]  r_reg1_o,
    output logic [4:0]  w_reg_o,
    output logic [31:0] imm_o
);
    import fe_pkg::*;

    inst_word_u word;
    logic [5:0] major;
    logic [2:0] reg_type;

    assign word  = inst_word_u'(inst_i);
    assign major = word.ri12.opcode[9:4];

    // a faulted fetch carries no usable word
    always_comb begin
        reg_type = REG_TYPE_I;
        if (!fetch_err_i) begin
            case (major)
                6'b000000: reg_type = REG_TYPE_RRW;
                6'b000001, 6'b000010, 6'b000011: reg_type = REG_TYPE_RW;
                // bit 24 splits stores from loads
                6'b001010: reg_type = word.ri12.opcode[2] ? REG_TYPE_RR : REG_TYPE_RW;
                6'b010101: reg_type = REG_TYPE_BL;
                6'b010110, 6'b010111, 6'b011000,
                6'b011001, 6'b011010, 6'b011011: reg_type = REG_TYPE_RR;
                default: reg_type = REG_TYPE_I;
            endcase
        end
    end

    always_comb begin
        r_reg0_o = 5'd0;
        r_reg1_o = 5'd0;
        w_reg_o  = 5'd0;
        imm_o    = 32'd0;
        case (reg_type)
            REG_TYPE_RRW: begin
                r_reg0_o = word.r3.rk;
                r_reg1_o = word.r3.rj;
                w_reg_o  = word.r3.rd;
            end
            REG_TYPE_RW: begin
                r_reg1_o = word.ri12.rj;
                w_reg_o  = word.ri12.rd;
                imm_o    = {{20{word.ri12.imm[11]}}, word.ri12.imm};
            end
            REG_TYPE_RR: begin
                // branches and stores read rd as a source
                r_reg0_o = word.ri12.rd;
                r_reg1_o = word.ri12.rj;
                imm_o    = {{20{word.ri12.imm[11]}}, word.ri12.imm};
            end
            REG_TYPE_BL: begin
                w_reg_o = 5'd1;
            end
            default: begin
                r_reg0_o = 5'd0;
            end
        endcase
    end

endmodule

/* design/frontend.sv */
`timescale 1ns/1ps

module frontend (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        flush_i,
    input  logic [31:0] redirect_pc_i,

    // instruction bus
    output logic        fetch_req_o,
    output logic [31:0] fetch_addr_o,
    input  logic        fetch_resp_valid_i,
    input  logic [63:0] fetch_data_i,
    input  logic        fetch_err_i,

    // issue side, slot 0 is the older one
    output logic [1:0]  inst_valid_o,
    input  logic [1:0]  issue_num_i,
    input  logic        backend_stall_i,
    output logic [fe_pkg::FETCH_WIDTH-1:0][31:0] pc_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][31:0] inst_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0]       fetch_err_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][4:0]  r_reg0_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][4:0]  r_reg1_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][4:0]  w_reg_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][31:0] imm_o
);
    import fe_pkg::*;

    logic                                       raw_ready;
    logic [1:0]                                 fetch_write_num;
    logic [FETCH_WIDTH-1:0][RAW_ENTRY_W-1:0]    fetch_write_data;
    logic [1:0]                                 raw_valid;
    logic [1:0]                                 raw_read_num;
    logic [FETCH_WIDTH-1:0][RAW_ENTRY_W-1:0]    raw_data;
    logic                                       dec_ready;
    logic [FETCH_WIDTH-1:0][4:0]                dec_r0;
    logic [FETCH_WIDTH-1:0][4:0]                dec_r1;
    logic [FETCH_WIDTH-1:0][4:0]                dec_w;
    logic [FETCH_WIDTH-1:0][31:0]               dec_imm;
    logic [FETCH_WIDTH-1:0][DEC_ENTRY_W-1:0]    dec_write_data;
    logic [FETCH_WIDTH-1:0][DEC_ENTRY_W-1:0]    dec_read_data;

    fetch_unit u_fetch_unit (
        .clk,
        .rst_n,
        .flush_i,
        .redirect_pc_i,
        .fifo_ready_i       (raw_ready),
        .fetch_req_o,
        .fetch_addr_o,
        .fetch_resp_valid_i,
        .fetch_data_i,
        .fetch_err_i,
        .write_num_o        (fetch_write_num),
        .write_data_o       (fetch_write_data)
    );

    multi_channel_fifo #(
        .DATA_WIDTH (RAW_ENTRY_W),
        .DEPTH      (RAW_FIFO_DEPTH)
    ) raw_fifo (
        .clk,
        .rst_n,
        .flush_i,
        .write_ready_o (raw_ready),
        .write_num_i   (fetch_write_num),
        .write_data_i  (fetch_write_data),
        .read_valid_o  (raw_valid),
        .read_ready_i  (dec_ready),
        .read_num_i    (raw_read_num),
        .read_data_o   (raw_data)
    );

    // move every valid raw slot at once
    assign raw_read_num = {raw_valid[1], raw_valid[0] & ~raw_valid[1]};

    inst_decoder dec0 (
        .inst_i      (raw_data[0][31:0]),
        .fetch_err_i (raw_data[0][64]),
        .r_reg0_o    (dec_r0[0]),
        .r_reg1_o    (dec_r1[0]),
        .w_reg_o     (dec_w[0]),
        .imm_o       (dec_imm[0])
    );

    inst_decoder dec1 (
        .inst_i      (raw_data[1][31:0]),
        .fetch_err_i (raw_data[1][64]),
        .r_reg0_o    (dec_r0[1]),
        .r_reg1_o    (dec_r1[1]),
        .w_reg_o     (dec_w[1]),
        .imm_o       (dec_imm[1])
    );

    assign dec_write_data[0] = {raw_data[0], dec_r0[0], dec_r1[0], dec_w[0], dec_imm[0]};
    assign dec_write_data[1] = {raw_data[1], dec_r0[1], dec_r1[1], dec_w[1], dec_imm[1]};

    multi_channel_fifo #(
        .DATA_WIDTH (DEC_ENTRY_W),
        .DEPTH      (DEC_FIFO_DEPTH)
    ) decoded_fifo (
        .clk,
        .rst_n,
        .flush_i,
        .write_ready_o (dec_ready),
        .write_num_i   (raw_read_num),
        .write_data_i  (dec_write_data),
        .read_valid_o  (inst_valid_o),
        .read_ready_i  (~backend_stall_i),
        .read_num_i    (issue_num_i),
        .read_data_o   (dec_read_data)
    );

    // unpack {err, pc, word, r0, r1, w, imm}
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            fetch_err_o[k] = dec_read_data[k][111];
            pc_o[k]        = dec_read_data[k][110:79];
            inst_o[k]      = dec_read_data[k][78:47];
            r_reg0_o[k]    = dec_read_data[k][46:42];
            r_reg1_o[k]    = dec_read_data[k][41:37];
            w_reg_o[k]     = dec_read_data[k][36:32];
            imm_o[k]       = dec_read_data[k][31:0];
        end
    end

endmodule

/* verification/frontend_properties.sv */
`timescale 1ns/1ps

module frontend_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        fetch_req_o,
    input logic [31:0] fetch_addr_o,
    input logic        fetch_resp_valid_i,
    input logic [1:0]  inst_valid_o
);

    // tracks the request that still waits for its response
    logic out_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= 1'b0;
        end else if (fetch_resp_valid_i) begin
            out_q <= 1'b0;
        end else if (fetch_req_o) begin
            out_q <= 1'b1;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_o |-> !out_q)
        else $error("fetch request issued while one is outstanding");

    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_o |-> fetch_addr_o[2:0] == 3'b000)
        else $error("fetch address not 8-byte aligned");

    a_valid_order: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid_o[1] |-> inst_valid_o[0])
        else $error("slot 1 valid without slot 0");

    a_valid_after_reset: assert property (@(posedge clk)
        !rst_n |=> inst_valid_o == 2'b00)
        else $error("inst_valid set right after reset");

endmodule

bind frontend frontend_properties props (.*);

/* verification/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;
    import fe_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        flush_i;
    logic [31:0] redirect_pc_i;
    logic        fetch_req_o;
    logic [31:0] fetch_addr_o;
    logic        fetch_resp_valid_i;
    logic [63:0] fetch_data_i;
    logic        fetch_err_i;
    logic [1:0]  inst_valid_o;
    logic [1:0]  issue_num_i;
    logic        backend_stall_i;
    logic [FETCH_WIDTH-1:0][31:0] pc_o;
    logic [FETCH_WIDTH-1:0][31:0] inst_o;
    logic [FETCH_WIDTH-1:0]       fetch_err_o;
    logic [FETCH_WIDTH-1:0][4:0]  r_reg0_o;
    logic [FETCH_WIDTH-1:0][4:0]  r_reg1_o;
    logic [FETCH_WIDTH-1:0][4:0]  w_reg_o;
    logic [FETCH_WIDTH-1:0][31:0] imm_o;

    // instruction memory window starting at RESET_PC
    logic [31:0] mem_tab [256];
    logic        err_tab [128];

    integer      seed = 32'h532e0a8a;
    int          errors = 0;
    int          checks = 0;
    int          issued = 0;
    int          err_issued = 0;
    int          flushes = 0;
    int          stall_pct = 0;
    int          flush_pct = 0;
    logic        force_odd = 1'b0;
    logic [31:0] exp_pc = RESET_PC;
    // next aligned pair the fetch side should ask for
    logic [31:0] exp_fetch = RESET_PC;

    // memory responder state
    logic        pend = 1'b0;
    int          resp_cnt = 0;
    logic [31:0] resp_addr = '0;

    frontend dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // word biased toward the opcodes the decoder knows
    task automatic make_word(output logic [31:0] word);
        logic [5:0] major;
        logic [31:0] r;
        r = $random(seed);
        case ({$random(seed)} % 10)
            0: major = 6'b000000;
            1: major = 6'b000001;
            2: major = 6'b000010;
            3: major = 6'b000011;
            4, 5: major = 6'b001010;
            6: major = 6'b010101;
            7, 8: major = 6'b010110 + 6'({$random(seed)} % 6);
            default: major = r[31:26];
        endcase
        word = {major, r[25:0]};
    endtask

    // expected register fields from the opcode classes
    task automatic ref_decode(input logic [31:0] w, input logic err,
                              output logic [4:0] r0, output logic [4:0] r1,
                              output logic [4:0] wr, output logic [31:0] imm);
        logic [2:0] cls;
        cls = REG_TYPE_I;
        if (!err) begin
            case (w[31:26])
                6'b000000: cls = REG_TYPE_RRW;
                6'b000001, 6'b000010, 6'b000011: cls = REG_TYPE_RW;
                6'b001010: cls = w[24] ? REG_TYPE_RR : REG_TYPE_RW;
                6'b010101: cls = REG_TYPE_BL;
                6'b010110, 6'b010111, 6'b011000,
                6'b011001, 6'b011010, 6'b011011: cls = REG_TYPE_RR;
                default: cls = REG_TYPE_I;
            endcase
        end
        r0 = '0;
        r1 = '0;
        wr = '0;
        imm = '0;
        if (cls == REG_TYPE_RRW) begin
            r0 = w[14:10];
            r1 = w[9:5];
            wr = w[4:0];
        end else if (cls == REG_TYPE_RW) begin
            r1 = w[9:5];
            wr = w[4:0];
            imm = {{20{w[21]}}, w[21:10]};
        end else if (cls == REG_TYPE_RR) begin
            r0 = w[4:0];
            r1 = w[9:5];
            imm = {{20{w[21]}}, w[21:10]};
        end else if (cls == REG_TYPE_BL) begin
            wr = 5'd1;
        end
    endtask

    task automatic check_slot(input int k);
        logic [31:0] w;
        logic        e;
        logic [4:0]  r0, r1, wr;
        logic [31:0] imm;
        w = mem_tab[exp_pc[9:2]];
        e = err_tab[exp_pc[9:3]];
        ref_decode(w, e, r0, r1, wr, imm);
        check($sformatf("slot%0d pc", k), pc_o[k], exp_pc);
        check($sformatf("slot%0d inst", k), inst_o[k], w);
        check($sformatf("slot%0d fetch_err", k), 32'(fetch_err_o[k]), 32'(e));
        check($sformatf("slot%0d r_reg0", k), 32'(r_reg0_o[k]), 32'(r0));
        check($sformatf("slot%0d r_reg1", k), 32'(r_reg1_o[k]), 32'(r1));
        check($sformatf("slot%0d w_reg", k), 32'(w_reg_o[k]), 32'(wr));
        check($sformatf("slot%0d imm", k), imm_o[k], imm);
        issued++;
        if (e) begin
            err_issued++;
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    // one clock cycle: drive on the falling edge, then sample
    task automatic step();
        logic [7:0] idx;
        int         avail;
        int         n;
        @(negedge clk);
        fetch_resp_valid_i = 1'b0;
        if (pend) begin
            resp_cnt--;
            if (resp_cnt == 0) begin
                fetch_resp_valid_i = 1'b1;
                fetch_data_i = {mem_tab[{resp_addr[9:3], 1'b1}], mem_tab[{resp_addr[9:3], 1'b0}]};
                fetch_err_i = err_tab[resp_addr[9:3]];
                pend = 1'b0;
            end
        end
        issue_num_i = 2'($random(seed));
        backend_stall_i = int'({$random(seed)} % 100) < stall_pct;
        flush_i = int'({$random(seed)} % 100) < flush_pct;
        if (flush_i) begin
            idx = 8'($random(seed));
            if (force_odd) begin
                idx[0] = 1'b1;
            end
            redirect_pc_i = RESET_PC + {22'd0, idx, 2'b00};
            flushes++;
        end
        #1;
        if (fetch_req_o) begin
            check("fetch_addr", fetch_addr_o, exp_fetch);
            exp_fetch = exp_fetch + 32'd8;
            pend = 1'b1;
            resp_cnt = 1 + int'({$random(seed)} % 4);
            resp_addr = fetch_addr_o;
        end
        check("inst_valid order", 32'(inst_valid_o[1] & ~inst_valid_o[0]), 32'd0);
        if (flush_i) begin
            exp_pc = redirect_pc_i;
            exp_fetch = {redirect_pc_i[31:3], 3'b000};
        end else if (!backend_stall_i) begin
            avail = inst_valid_o[1] ? 2 : int'(inst_valid_o[0]);
            n = (int'(issue_num_i) < avail) ? int'(issue_num_i) : avail;
            for (int k = 0; k < n; k++) begin
                check_slot(k);
            end
        end
    endtask

    function automatic int counter(input int which);
        if (which == 1) begin
            return err_issued;
        end else if (which == 2) begin
            return flushes;
        end
        return issued;
    endfunction

    // run cycles until a counter has grown, or give up
    task automatic run_until(input string name, input int which, input int amount,
                             input int limit);
        int start;
        int cycles;
        int err0;
        start = counter(which);
        cycles = 0;
        err0 = errors;
        while (counter(which) < start + amount && cycles < limit) begin
            step();
            cycles++;
        end
        if (counter(which) < start + amount) begin
            errors++;
            $display("timeout: test %s did not reach its goal within %0d cycles", name, limit);
        end
        $display("test %s finished: %0d cycles, %0d new errors", name, cycles, errors - err0);
    endtask

    initial begin
        rst_n = 1'b0;
        flush_i = 1'b0;
        redirect_pc_i = '0;
        fetch_resp_valid_i = 1'b0;
        fetch_data_i = '0;
        fetch_err_i = 1'b0;
        issue_num_i = '0;
        backend_stall_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            make_word(mem_tab[i]);
        end
        // about one pair in eight faults
        for (int i = 0; i < 128; i++) begin
            err_tab[i] = ({$random(seed)} % 8) == 0;
        end

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check("fetch_req in reset", 32'(fetch_req_o), 32'd0);
                check("inst_valid in reset", 32'(inst_valid_o), 32'd0);
            end
        end
        rst_n = 1'b1;
        #1;
        check("inst_valid after reset", 32'(inst_valid_o), 32'd0);
        $display("test reset finished: %0d errors", errors);

        run_until("sequential", 0, 80, 2000);
        force_odd = 1'b1;
        flush_pct = 4;
        run_until("flush_redirect", 2, 10, 3000);
        flush_pct = 0;
        run_until("after_flush", 0, 30, 2000);
        force_odd = 1'b0;
        stall_pct = 70;
        flush_pct = 1;
        run_until("stall_backpressure", 0, 150, 8000);
        stall_pct = 10;
        flush_pct = 0;
        run_until("fetch_error", 1, 6, 10000);

        $display("summary: %0d checks, %0d errors, %0d issued, %0d flushes",
                 checks, errors, issued, flushes);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/fe_pkg.sv
design/fetch_unit.sv
design/multi_channel_fifo.sv
design/inst_decoder.sv
design/frontend.sv
verification/frontend_properties.sv
verification/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontend_tb
LOG       ?= sim.log
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
